//--- src/ray_pkg.sv
`default_nettype none

package ray_pkg;

  // One signed coordinate or direction component
  localparam int COORD_W = 12;

  // Unsigned squared sphere radius
  localparam int RSQ_W = 26;

  // Signed projection of the sphere center onto the ray
  localparam int DIST_W = 28;

  // Width of the discriminant terms in the intersector
  localparam int WIDE_W = 64;

  // Material word, id in the top 8 bits and color in the low 24
  localparam int MAT_W = 32;

  // Scene buffer size
  localparam int SCENE_DEPTH = 16;
  localparam int IDX_W = $clog2(SCENE_DEPTH);

  // Pipeline latencies in cycles
  localparam int BUF_LATENCY = 2;
  localparam int INTX_DELAY = 4;

  // Object sequencer states
  typedef enum logic {
    SEQ_IDLE,
    SEQ_SCAN
  } seq_state_t;

endpackage

`default_nettype wire

//--- src/delay_line.sv
`default_nettype none
`timescale 1ns/1ns

module delay_line #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 1
) (
  input wire clk,
  input wire rst,
  input wire [WIDTH-1:0] in_data,
  input wire in_valid,
  output logic [WIDTH-1:0] out_data,
  output logic out_valid
);

  logic [WIDTH-1:0] data_q [DEPTH];
  logic [DEPTH-1:0] valid_q;

  always_ff @(posedge clk) begin
    data_q[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  assign out_data = data_q[DEPTH-1];
  assign out_valid = valid_q[DEPTH-1];

endmodule

`default_nettype wire

//--- src/scene_buffer.sv
`default_nettype none
`timescale 1ns/1ns

module scene_buffer (
  input wire clk,
  input wire rst,
  input wire we,
  input wire [ray_pkg::IDX_W-1:0] waddr,
  input wire signed [ray_pkg::COORD_W-1:0] wcenter_x,
  input wire signed [ray_pkg::COORD_W-1:0] wcenter_y,
  input wire signed [ray_pkg::COORD_W-1:0] wcenter_z,
  input wire [ray_pkg::RSQ_W-1:0] wrsq,
  input wire [ray_pkg::MAT_W-1:0] wmat,
  input wire rd_en,
  input wire [ray_pkg::IDX_W-1:0] rd_idx,
  input wire rd_last,
  output logic signed [ray_pkg::COORD_W-1:0] center_x,
  output logic signed [ray_pkg::COORD_W-1:0] center_y,
  output logic signed [ray_pkg::COORD_W-1:0] center_z,
  output logic [ray_pkg::RSQ_W-1:0] rsq,
  output logic [ray_pkg::MAT_W-1:0] mat,
  output logic obj_valid,
  output logic obj_last
);

  logic signed [ray_pkg::COORD_W-1:0] cx_mem [ray_pkg::SCENE_DEPTH];
  logic signed [ray_pkg::COORD_W-1:0] cy_mem [ray_pkg::SCENE_DEPTH];
  logic signed [ray_pkg::COORD_W-1:0] cz_mem [ray_pkg::SCENE_DEPTH];
  logic [ray_pkg::RSQ_W-1:0] rsq_mem [ray_pkg::SCENE_DEPTH];
  logic [ray_pkg::MAT_W-1:0] mat_mem [ray_pkg::SCENE_DEPTH];
  logic [ray_pkg::IDX_W-1:0] rd_idx_q;

  always_ff @(posedge clk) begin
    if (we) begin
      cx_mem[waddr] <= wcenter_x;
      cy_mem[waddr] <= wcenter_y;
      cz_mem[waddr] <= wcenter_z;
      rsq_mem[waddr] <= wrsq;
      mat_mem[waddr] <= wmat;
    end
  end

  // Registered address, then registered data, like a block RAM
  always_ff @(posedge clk) begin
    rd_idx_q <= rd_idx;
    center_x <= cx_mem[rd_idx_q];
    center_y <= cy_mem[rd_idx_q];
    center_z <= cz_mem[rd_idx_q];
    rsq <= rsq_mem[rd_idx_q];
    mat <= mat_mem[rd_idx_q];
  end

  // Valid and last flags follow the read through the same two stages
  delay_line #(
    .WIDTH(1),
    .DEPTH(ray_pkg::BUF_LATENCY)
  ) flag_pipe (
    .clk(clk),
    .rst(rst),
    .in_data(rd_last),
    .in_valid(rd_en),
    .out_data(obj_last),
    .out_valid(obj_valid)
  );

endmodule

`default_nettype wire

//--- src/object_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

module object_sequencer (
  input wire clk,
  input wire rst,
  input wire start,
  input wire done,
  input wire [ray_pkg::IDX_W:0] scene_count,
  output logic rd_en,
  output logic [ray_pkg::IDX_W-1:0] rd_idx,
  output logic rd_last,
  output logic busy
);

  ray_pkg::seq_state_t state;
  logic [ray_pkg::IDX_W:0] next_idx;

  // One bit wider than rd_idx so it can be compared with scene_count
  assign next_idx = {1'b0, rd_idx} + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ray_pkg::SEQ_IDLE;
      rd_en <= 1'b0;
      rd_idx <= '0;
      rd_last <= 1'b0;
      busy <= 1'b0;
    end else begin
      case (state)
        ray_pkg::SEQ_IDLE: begin
          if (start && !busy) begin
            state <= ray_pkg::SEQ_SCAN;
            rd_en <= 1'b1;
            rd_idx <= '0;
            rd_last <= (scene_count == 1);
          end
        end
        ray_pkg::SEQ_SCAN: begin
          if (rd_last) begin
            state <= ray_pkg::SEQ_IDLE;
            rd_en <= 1'b0;
            rd_last <= 1'b0;
          end else begin
            rd_idx <= next_idx[ray_pkg::IDX_W-1:0];
            rd_last <= (next_idx + 1'b1 == scene_count);
          end
        end
        default: state <= ray_pkg::SEQ_IDLE;
      endcase

      // Busy spans the whole pass, until the selector reports done
      if (start && !busy) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    rd_en |-> ({1'b0, rd_idx} < scene_count));

endmodule

`default_nettype wire

//--- src/sphere_intersector.sv
`default_nettype none
`timescale 1ns/1ns

module sphere_intersector (
  input wire clk,
  input wire rst,
  input wire signed [ray_pkg::COORD_W-1:0] origin_x,
  input wire signed [ray_pkg::COORD_W-1:0] origin_y,
  input wire signed [ray_pkg::COORD_W-1:0] origin_z,
  input wire signed [ray_pkg::COORD_W-1:0] dir_x,
  input wire signed [ray_pkg::COORD_W-1:0] dir_y,
  input wire signed [ray_pkg::COORD_W-1:0] dir_z,
  input wire signed [ray_pkg::COORD_W-1:0] center_x,
  input wire signed [ray_pkg::COORD_W-1:0] center_y,
  input wire signed [ray_pkg::COORD_W-1:0] center_z,
  input wire [ray_pkg::RSQ_W-1:0] rsq,
  input wire in_valid,
  input wire in_last,
  output logic hit,
  output logic signed [ray_pkg::DIST_W-1:0] tca,
  output logic out_valid,
  output logic out_last
);

  // Stage 1, vector from the ray origin to the sphere center
  logic signed [ray_pkg::COORD_W:0] lx_q1;
  logic signed [ray_pkg::COORD_W:0] ly_q1;
  logic signed [ray_pkg::COORD_W:0] lz_q1;
  logic [ray_pkg::RSQ_W-1:0] rsq_q1;

  // Stage 2, dot products
  logic signed [ray_pkg::DIST_W-1:0] tca_q2;
  logic signed [ray_pkg::DIST_W-1:0] ll_q2;
  logic signed [ray_pkg::DIST_W-1:0] dd_q2;
  logic [ray_pkg::RSQ_W-1:0] rsq_q2;

  // Stage 3, both sides of the distance test scaled by dir.dir
  logic signed [ray_pkg::DIST_W-1:0] tca_q3;
  logic signed [ray_pkg::WIDE_W-1:0] perp_q3;
  logic signed [ray_pkg::WIDE_W-1:0] rsqdd_q3;

  logic [2:0] valid_q;
  logic [2:0] last_q;

  always_ff @(posedge clk) begin
    lx_q1 <= center_x - origin_x;
    ly_q1 <= center_y - origin_y;
    lz_q1 <= center_z - origin_z;
    rsq_q1 <= rsq;

    tca_q2 <= lx_q1 * dir_x + ly_q1 * dir_y + lz_q1 * dir_z;
    ll_q2 <= lx_q1 * lx_q1 + ly_q1 * ly_q1 + lz_q1 * lz_q1;
    dd_q2 <= dir_x * dir_x + dir_y * dir_y + dir_z * dir_z;
    rsq_q2 <= rsq_q1;

    // Squared distance from center to ray, times |dir|^2
    perp_q3 <= ll_q2 * dd_q2 - tca_q2 * tca_q2;
    rsqdd_q3 <= $signed({1'b0, rsq_q2}) * dd_q2;
    tca_q3 <= tca_q2;

    // Sphere must lie ahead of the origin and reach the ray
    hit <= (tca_q3 > 0) && (perp_q3 <= rsqdd_q3);
    tca <= tca_q3;

    last_q <= {last_q[1:0], in_last};
    out_last <= last_q[2];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      out_valid <= 1'b0;
    end else begin
      valid_q <= {valid_q[1:0], in_valid};
      out_valid <= valid_q[2];
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    in_valid |-> ##(ray_pkg::INTX_DELAY) out_valid);

endmodule

`default_nettype wire

//--- src/hit_selector.sv
`default_nettype none
`timescale 1ns/1ns

module hit_selector (
  input wire clk,
  input wire rst,
  input wire start,
  input wire res_valid,
  input wire res_hit,
  input wire signed [ray_pkg::DIST_W-1:0] res_tca,
  input wire res_last,
  input wire [ray_pkg::MAT_W-1:0] res_mat,
  output logic hit_any,
  output logic signed [ray_pkg::DIST_W-1:0] hit_tca,
  output logic [ray_pkg::MAT_W-1:0] hit_mat,
  output logic done
);

  logic take;

  // Strictly closer only, so on a tie the earlier object stays
  assign take = !start && res_valid && res_hit && (!hit_any || res_tca < hit_tca);

  always_ff @(posedge clk) begin
    if (rst) begin
      hit_any <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= res_valid && res_last;
      if (start) begin
        hit_any <= 1'b0;
      end else if (take) begin
        hit_any <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      hit_tca <= res_tca;
      hit_mat <= res_mat;
    end
  end

  // Only one object per pass carries last
  assert property (@(posedge clk) disable iff (rst)
    done |=> !done);

endmodule

`default_nettype wire

//--- src/ray_intersector.sv
`default_nettype none
`timescale 1ns/1ns

module ray_intersector (
  input wire clk,
  input wire rst,
  input wire scene_we,
  input wire [ray_pkg::IDX_W-1:0] scene_waddr,
  input wire signed [ray_pkg::COORD_W-1:0] scene_wcenter_x,
  input wire signed [ray_pkg::COORD_W-1:0] scene_wcenter_y,
  input wire signed [ray_pkg::COORD_W-1:0] scene_wcenter_z,
  input wire [ray_pkg::RSQ_W-1:0] scene_wrsq,
  input wire [ray_pkg::MAT_W-1:0] scene_wmat,
  input wire [ray_pkg::IDX_W:0] scene_count,
  input wire start,
  input wire signed [ray_pkg::COORD_W-1:0] ray_origin_x,
  input wire signed [ray_pkg::COORD_W-1:0] ray_origin_y,
  input wire signed [ray_pkg::COORD_W-1:0] ray_origin_z,
  input wire signed [ray_pkg::COORD_W-1:0] ray_dir_x,
  input wire signed [ray_pkg::COORD_W-1:0] ray_dir_y,
  input wire signed [ray_pkg::COORD_W-1:0] ray_dir_z,
  output logic busy,
  output logic done,
  output logic hit_any,
  output logic signed [ray_pkg::DIST_W-1:0] hit_tca,
  output logic [ray_pkg::MAT_W-1:0] hit_mat
);

  logic start_accept;
  logic signed [ray_pkg::COORD_W-1:0] org_x;
  logic signed [ray_pkg::COORD_W-1:0] org_y;
  logic signed [ray_pkg::COORD_W-1:0] org_z;
  logic signed [ray_pkg::COORD_W-1:0] dir_x;
  logic signed [ray_pkg::COORD_W-1:0] dir_y;
  logic signed [ray_pkg::COORD_W-1:0] dir_z;

  logic rd_en;
  logic [ray_pkg::IDX_W-1:0] rd_idx;
  logic rd_last;

  logic signed [ray_pkg::COORD_W-1:0] obj_cx;
  logic signed [ray_pkg::COORD_W-1:0] obj_cy;
  logic signed [ray_pkg::COORD_W-1:0] obj_cz;
  logic [ray_pkg::RSQ_W-1:0] obj_rsq;
  logic [ray_pkg::MAT_W-1:0] obj_mat;
  logic obj_valid;
  logic obj_last;

  logic res_valid;
  logic res_hit;
  logic signed [ray_pkg::DIST_W-1:0] res_tca;
  logic res_last;
  logic [ray_pkg::MAT_W-1:0] res_mat;

  // A start during a pass is dropped
  assign start_accept = start && !busy;

  // Ray stays fixed for the whole pass
  always_ff @(posedge clk) begin
    if (start_accept) begin
      org_x <= ray_origin_x;
      org_y <= ray_origin_y;
      org_z <= ray_origin_z;
      dir_x <= ray_dir_x;
      dir_y <= ray_dir_y;
      dir_z <= ray_dir_z;
    end
  end

  object_sequencer seq (
    .clk(clk),
    .rst(rst),
    .start(start),
    .done(done),
    .scene_count(scene_count),
    .rd_en(rd_en),
    .rd_idx(rd_idx),
    .rd_last(rd_last),
    .busy(busy)
  );

  scene_buffer scene (
    .clk(clk),
    .rst(rst),
    .we(scene_we),
    .waddr(scene_waddr),
    .wcenter_x(scene_wcenter_x),
    .wcenter_y(scene_wcenter_y),
    .wcenter_z(scene_wcenter_z),
    .wrsq(scene_wrsq),
    .wmat(scene_wmat),
    .rd_en(rd_en),
    .rd_idx(rd_idx),
    .rd_last(rd_last),
    .center_x(obj_cx),
    .center_y(obj_cy),
    .center_z(obj_cz),
    .rsq(obj_rsq),
    .mat(obj_mat),
    .obj_valid(obj_valid),
    .obj_last(obj_last)
  );

  sphere_intersector sphere_intx (
    .clk(clk),
    .rst(rst),
    .origin_x(org_x),
    .origin_y(org_y),
    .origin_z(org_z),
    .dir_x(dir_x),
    .dir_y(dir_y),
    .dir_z(dir_z),
    .center_x(obj_cx),
    .center_y(obj_cy),
    .center_z(obj_cz),
    .rsq(obj_rsq),
    .in_valid(obj_valid),
    .in_last(obj_last),
    .hit(res_hit),
    .tca(res_tca),
    .out_valid(res_valid),
    .out_last(res_last)
  );

  // Material rides beside the geometry so it meets its own result
  delay_line #(
    .WIDTH(ray_pkg::MAT_W),
    .DEPTH(ray_pkg::INTX_DELAY)
  ) mat_pipe (
    .clk(clk),
    .rst(rst),
    .in_data(obj_mat),
    .in_valid(obj_valid),
    .out_data(res_mat),
    .out_valid()
  );

  hit_selector selector (
    .clk(clk),
    .rst(rst),
    .start(start_accept),
    .res_valid(res_valid),
    .res_hit(res_hit),
    .res_tca(res_tca),
    .res_last(res_last),
    .res_mat(res_mat),
    .hit_any(hit_any),
    .hit_tca(hit_tca),
    .hit_mat(hit_mat),
    .done(done)
  );

endmodule

`default_nettype wire

//--- tests/ray_intersector_tb.sv
`default_nettype none
`timescale 1ns/1ns

module ray_intersector_tb;

  localparam int CLK_PERIOD = 10;
  localparam int RANDOM_PASSES = 200;
  localparam int TIMING_PASSES = 30;
  localparam int POKE_PASSES = 10;
  // Six directed passes plus the random ones
  localparam int TOTAL_PASSES = 6 + RANDOM_PASSES + TIMING_PASSES + POKE_PASSES;
  localparam int DONE_LIMIT = ray_pkg::SCENE_DEPTH + 20;
  localparam longint WATCHDOG_NS = (TOTAL_PASSES * DONE_LIMIT + 500) * CLK_PERIOD;

  logic clk = 1'b0;
  logic rst;
  logic scene_we;
  logic [ray_pkg::IDX_W-1:0] scene_waddr;
  logic signed [ray_pkg::COORD_W-1:0] scene_wcenter_x;
  logic signed [ray_pkg::COORD_W-1:0] scene_wcenter_y;
  logic signed [ray_pkg::COORD_W-1:0] scene_wcenter_z;
  logic [ray_pkg::RSQ_W-1:0] scene_wrsq;
  logic [ray_pkg::MAT_W-1:0] scene_wmat;
  logic [ray_pkg::IDX_W:0] scene_count;
  logic start;
  logic signed [ray_pkg::COORD_W-1:0] ray_origin_x;
  logic signed [ray_pkg::COORD_W-1:0] ray_origin_y;
  logic signed [ray_pkg::COORD_W-1:0] ray_origin_z;
  logic signed [ray_pkg::COORD_W-1:0] ray_dir_x;
  logic signed [ray_pkg::COORD_W-1:0] ray_dir_y;
  logic signed [ray_pkg::COORD_W-1:0] ray_dir_z;
  logic busy;
  logic done;
  logic hit_any;
  logic signed [ray_pkg::DIST_W-1:0] hit_tca;
  logic [ray_pkg::MAT_W-1:0] hit_mat;

  int seed;
  int error_count;
  int check_count;
  int test_errors;
  int tests_run;
  int tests_failed;
  int n;
  int a;
  int b;

  // Model copy of the scene
  int m_cx [ray_pkg::SCENE_DEPTH];
  int m_cy [ray_pkg::SCENE_DEPTH];
  int m_cz [ray_pkg::SCENE_DEPTH];
  longint m_rsq [ray_pkg::SCENE_DEPTH];
  logic [ray_pkg::MAT_W-1:0] m_mat [ray_pkg::SCENE_DEPTH];

  // Ray for the next pass
  int ray_ox;
  int ray_oy;
  int ray_oz;
  int ray_dx;
  int ray_dy;
  int ray_dz;

  ray_intersector uut (
    .clk(clk),
    .rst(rst),
    .scene_we(scene_we),
    .scene_waddr(scene_waddr),
    .scene_wcenter_x(scene_wcenter_x),
    .scene_wcenter_y(scene_wcenter_y),
    .scene_wcenter_z(scene_wcenter_z),
    .scene_wrsq(scene_wrsq),
    .scene_wmat(scene_wmat),
    .scene_count(scene_count),
    .start(start),
    .ray_origin_x(ray_origin_x),
    .ray_origin_y(ray_origin_y),
    .ray_origin_z(ray_origin_z),
    .ray_dir_x(ray_dir_x),
    .ray_dir_y(ray_dir_y),
    .ray_dir_z(ray_dir_z),
    .busy(busy),
    .done(done),
    .hit_any(hit_any),
    .hit_tca(hit_tca),
    .hit_mat(hit_mat)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  task automatic check_value(input string what, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d, %s: ok", tests_run, name);
    end else begin
      $display("test %0d, %s: FAIL with %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic write_object(input int idx, input int cx, input int cy, input int cz,
                              input longint rsq, input logic [ray_pkg::MAT_W-1:0] mat);
    @(posedge clk);
    scene_we <= 1'b1;
    scene_waddr <= idx[ray_pkg::IDX_W-1:0];
    scene_wcenter_x <= cx[ray_pkg::COORD_W-1:0];
    scene_wcenter_y <= cy[ray_pkg::COORD_W-1:0];
    scene_wcenter_z <= cz[ray_pkg::COORD_W-1:0];
    scene_wrsq <= rsq[ray_pkg::RSQ_W-1:0];
    scene_wmat <= mat;
    m_cx[idx] = cx;
    m_cy[idx] = cy;
    m_cz[idx] = cz;
    m_rsq[idx] = rsq;
    m_mat[idx] = mat;
  endtask

  task automatic end_writes();
    @(posedge clk);
    scene_we <= 1'b0;
  endtask

  task automatic random_object(input int idx);
    write_object(idx, rand_range(-1000, 1000), rand_range(-1000, 1000),
                 rand_range(-1000, 1000), rand_range(0, 262144), $random(seed));
  endtask

  task automatic set_ray(input int ox, input int oy, input int oz,
                         input int dx, input int dy, input int dz);
    ray_ox = ox;
    ray_oy = oy;
    ray_oz = oz;
    ray_dx = dx;
    ray_dy = dy;
    ray_dz = dz;
  endtask

  task automatic random_ray();
    set_ray(rand_range(-200, 200), rand_range(-200, 200), rand_range(-200, 200),
            rand_range(-64, 64), rand_range(-64, 64), rand_range(-64, 64));
    if (ray_dx == 0 && ray_dy == 0 && ray_dz == 0) begin
      ray_dz = 1;
    end
  endtask

  // Hit needs the sphere ahead of the origin and within its radius of the ray
  // Nearest by projection wins and the earliest slot wins a tie
  task automatic model_nearest(input int count, output bit any, output longint best_tca,
                               output logic [ray_pkg::MAT_W-1:0] best_mat);
    longint lx;
    longint ly;
    longint lz;
    longint tca;
    longint ll;
    longint dd;
    any = 1'b0;
    best_tca = 0;
    best_mat = '0;
    dd = longint'(ray_dx) * ray_dx + longint'(ray_dy) * ray_dy + longint'(ray_dz) * ray_dz;
    for (int i = 0; i < count; i++) begin
      lx = m_cx[i] - ray_ox;
      ly = m_cy[i] - ray_oy;
      lz = m_cz[i] - ray_oz;
      tca = lx * ray_dx + ly * ray_dy + lz * ray_dz;
      ll = lx * lx + ly * ly + lz * lz;
      if (tca > 0 && ll * dd - tca * tca <= m_rsq[i] * dd) begin
        if (!any || tca < best_tca) begin
          any = 1'b1;
          best_tca = tca;
          best_mat = m_mat[i];
        end
      end
    end
  endtask

  // Run one pass and compare with the model
  // A nonzero poke_at drives a second start with another ray in that cycle
  task automatic run_pass(input int count, input int poke_at);
    bit exp_hit;
    longint exp_tca;
    logic [ray_pkg::MAT_W-1:0] exp_mat;
    int cyc;
    bit seen;
    int poke_ox;
    int poke_dx;
    int poke_dz;
    model_nearest(count, exp_hit, exp_tca, exp_mat);
    cyc = 0;
    seen = 1'b0;
    @(posedge clk);
    scene_count <= count[ray_pkg::IDX_W:0];
    start <= 1'b1;
    ray_origin_x <= ray_ox[ray_pkg::COORD_W-1:0];
    ray_origin_y <= ray_oy[ray_pkg::COORD_W-1:0];
    ray_origin_z <= ray_oz[ray_pkg::COORD_W-1:0];
    ray_dir_x <= ray_dx[ray_pkg::COORD_W-1:0];
    ray_dir_y <= ray_dy[ray_pkg::COORD_W-1:0];
    ray_dir_z <= ray_dz[ray_pkg::COORD_W-1:0];
    @(posedge clk);
    start <= 1'b0;
    while (!seen && cyc < DONE_LIMIT) begin
      @(negedge clk);
      cyc++;
      if (done) begin
        seen = 1'b1;
      end else begin
        check_value("busy during pass", busy, 1);
        @(posedge clk);
        start <= (cyc == poke_at);
        if (cyc == poke_at) begin
          poke_ox = rand_range(-200, 200);
          poke_dx = rand_range(-64, 64);
          poke_dz = rand_range(-64, 64);
          ray_origin_x <= poke_ox[ray_pkg::COORD_W-1:0];
          ray_dir_x <= poke_dx[ray_pkg::COORD_W-1:0];
          ray_dir_z <= poke_dz[ray_pkg::COORD_W-1:0];
        end
      end
    end
    if (!seen) begin
      $display("Error at %0t ns: done did not arrive within %0d cycles of start",
               $time, DONE_LIMIT);
      error_count++;
      test_errors++;
    end else begin
      check_value("done latency", cyc, count + 7);
      check_value("hit_any", hit_any, exp_hit);
      if (exp_hit) begin
        check_value("hit_tca", hit_tca, exp_tca);
        check_value("hit_mat", hit_mat, exp_mat);
      end
      @(negedge clk);
      check_value("busy after done", busy, 0);
      check_value("done after its pulse", done, 0);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed = 32'h542157ce;
    error_count = 0;
    check_count = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst <= 1'b1;
    scene_we <= 1'b0;
    scene_waddr <= '0;
    scene_wcenter_x <= '0;
    scene_wcenter_y <= '0;
    scene_wcenter_z <= '0;
    scene_wrsq <= '0;
    scene_wmat <= '0;
    scene_count <= 1;
    start <= 1'b0;
    ray_origin_x <= '0;
    ray_origin_y <= '0;
    ray_origin_z <= '0;
    ray_dir_x <= '0;
    ray_dir_y <= '0;
    ray_dir_z <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_value("busy after reset", busy, 0);
    check_value("done after reset", done, 0);
    check_value("hit_any after reset", hit_any, 0);
    finish_test("reset values");

    write_object(0, 0, 0, 200, 2500, 32'h07ff8000);
    end_writes();
    set_ray(0, 0, 0, 0, 0, 16);
    run_pass(1, 0);
    check_value("hit_any on axis", hit_any, 1);
    check_value("hit_mat on axis", hit_mat, 32'h07ff8000);
    finish_test("single sphere on axis");

    // Behind the origin, then beside the ray beyond its radius
    write_object(0, 0, 0, -200, 2500, 32'h01000010);
    end_writes();
    run_pass(1, 0);
    check_value("hit_any behind origin", hit_any, 0);
    write_object(0, 300, 0, 200, 10000, 32'h02000020);
    end_writes();
    run_pass(1, 0);
    check_value("hit_any off axis", hit_any, 0);
    finish_test("miss cases");

    for (int i = 0; i < ray_pkg::SCENE_DEPTH; i++) begin
      random_object(i);
    end
    end_writes();
    for (int p = 0; p < RANDOM_PASSES; p++) begin
      random_object(rand_range(0, ray_pkg::SCENE_DEPTH - 1));
      a = rand_range(0, ray_pkg::SCENE_DEPTH - 1);
      b = rand_range(0, ray_pkg::SCENE_DEPTH - 1);
      // Same geometry in two slots gives equal t_ca
      write_object(b, m_cx[a], m_cy[a], m_cz[a], m_rsq[a], $random(seed));
      end_writes();
      random_ray();
      run_pass(ray_pkg::SCENE_DEPTH, 0);
    end
    for (int i = 0; i < ray_pkg::SCENE_DEPTH; i++) begin
      write_object(i, 0, 0, -800 - i, 100, 32'h10000000 + i);
    end
    write_object(3, 0, 0, 150, 400, 32'h03aa0000);
    write_object(9, 0, 0, 150, 400, 32'h09bb0000);
    write_object(12, 0, 0, 600, 400, 32'h0ccc0000);
    end_writes();
    set_ray(0, 0, 0, 0, 0, 4);
    run_pass(ray_pkg::SCENE_DEPTH, 0);
    check_value("hit_mat on tie", hit_mat, 32'h03aa0000);
    finish_test("nearest of many and ties");

    for (int i = 0; i < ray_pkg::SCENE_DEPTH; i++) begin
      random_object(i);
    end
    end_writes();
    for (int p = 0; p < TIMING_PASSES; p++) begin
      random_ray();
      run_pass(rand_range(1, ray_pkg::SCENE_DEPTH), 0);
    end
    finish_test("done timing");

    for (int p = 0; p < POKE_PASSES; p++) begin
      random_ray();
      n = rand_range(1, ray_pkg::SCENE_DEPTH);
      run_pass(n, rand_range(1, n + 4));
    end
    finish_test("start while busy");

    // Nearer spheres sit in the slots past scene_count
    for (int i = 0; i < ray_pkg::SCENE_DEPTH; i++) begin
      if (i < 4) begin
        write_object(i, 0, 0, 500 + 100 * i, 900, 32'h20000000 + i);
      end else begin
        write_object(i, 0, 0, 40 + i, 400, 32'h30000000 + i);
      end
    end
    end_writes();
    set_ray(0, 0, 0, 0, 0, 8);
    run_pass(4, 0);
    check_value("hit_mat with slots past count", hit_mat, 32'h20000000);
    write_object(2, 0, 0, 100, 900, 32'h2f000002);
    end_writes();
    run_pass(4, 0);
    check_value("hit_mat after rewrite", hit_mat, 32'h2f000002);
    finish_test("rewrite between passes");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
src/ray_pkg.sv
src/delay_line.sv
src/scene_buffer.sv
src/object_sequencer.sv
src/sphere_intersector.sv
src/hit_selector.sv
src/ray_intersector.sv
tests/ray_intersector_tb.sv

//--- Bender.yml
package:
  name: ray_intersector

sources:
  - src/ray_pkg.sv
  - src/delay_line.sv
  - src/scene_buffer.sv
  - src/object_sequencer.sv
  - src/sphere_intersector.sv
  - src/hit_selector.sv
  - src/ray_intersector.sv
  - target: test
    files:
      - tests/ray_intersector_tb.sv
